// File: include/boot_cpu_macros.svh
`ifndef BOOT_CPU_MACROS_SVH
`define BOOT_CPU_MACROS_SVH

// program RAM geometry.
`define BOOT_ADDR_WIDTH 8
`define BOOT_WORD_WIDTH 16

// host protocol bytes.
`define BOOT_SYNC_BYTE 8'h99
`define BOOT_DONE_BYTE 8'hAA

`endif

// File: design/boot_cpu_pkg.sv
`include "boot_cpu_macros.svh"

package boot_cpu_pkg;

    typedef enum logic [4:0] {
        INIT,
        TRANSMIT_SYNC,
        RECEIVE_SIZE,
        RECEIVE_PROGRAM,
        TRANSMIT_DONE,
        IF,
        IF_ID,
        ID,
        ID_EX,
        EX_MEM,
        MEM,
        MEM_WB,
        WB,
        WB_IF
    } ctrl_state_e;

    typedef enum logic [3:0] {
        NOP  = 4'h0,
        LDI  = 4'h1,
        ADDI = 4'h2,
        SUBI = 4'h3,
        LD   = 4'h4,
        ST   = 4'h5,
        IN   = 4'h6,
        OUT  = 4'h7,
        JMP  = 4'h8,
        JZ   = 4'h9
    } opcode_e;

    typedef struct packed {
        opcode_e                     op;
        logic [3:0]                  unused;
        logic [`BOOT_ADDR_WIDTH-1:0] operand; // immediate or address.
    } instr_t;

    ////////////////////
    // controller traffic
    ////////////////////

    typedef struct packed {
        logic transmit_sync;
        logic receive_size;
        logic receive_program;
        logic transmit_done;
        logic run;
    } boot_ctrl_t;

    typedef struct packed {
        logic sync_sent;
        logic size_received;
        logic program_received;
        logic done_sent;
    } boot_status_t;

    typedef struct packed {
        logic wb_if;
        logic if_id;
        logic id_ex;
        logic ex_mem;
        logic mem_wb;
        logic stdout_write;
        logic ram_write;
        logic reg_write;
        logic pipeline_reset_n;
    } stage_enables_t;

    typedef struct packed {
        logic                        en;
        logic [`BOOT_ADDR_WIDTH-1:0] addr;
        logic [`BOOT_WORD_WIDTH-1:0] data;
    } ram_write_t;

endpackage

// File: design/state_controller.sv
`timescale 1ns/1ps

module state_controller (
    input  logic                         clk,
    input  logic                         reset_n,
    input  logic                         stall,
    input  boot_cpu_pkg::boot_status_t   status,
    output boot_cpu_pkg::boot_ctrl_t     boot_ctrl,
    output boot_cpu_pkg::stage_enables_t enables
);

    boot_cpu_pkg::ctrl_state_e state;
    boot_cpu_pkg::ctrl_state_e state_next;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            state <= boot_cpu_pkg::INIT;
        end else begin
            state <= state_next;
        end
    end

    ////////////////////
    // next state
    ////////////////////

    always_comb begin
        state_next = state;
        case (state)
            boot_cpu_pkg::INIT: begin
                state_next = boot_cpu_pkg::TRANSMIT_SYNC;
            end
            boot_cpu_pkg::TRANSMIT_SYNC: begin
                if (status.sync_sent) begin
                    state_next = boot_cpu_pkg::RECEIVE_SIZE;
                end
            end
            boot_cpu_pkg::RECEIVE_SIZE: begin
                if (status.size_received) begin
                    state_next = boot_cpu_pkg::RECEIVE_PROGRAM;
                end
            end
            boot_cpu_pkg::RECEIVE_PROGRAM: begin
                if (status.program_received) begin
                    state_next = boot_cpu_pkg::TRANSMIT_DONE;
                end
            end
            boot_cpu_pkg::TRANSMIT_DONE: begin
                if (status.done_sent) begin
                    state_next = boot_cpu_pkg::IF;
                end
            end
            boot_cpu_pkg::IF:     state_next = boot_cpu_pkg::IF_ID;
            boot_cpu_pkg::IF_ID:  state_next = boot_cpu_pkg::ID;
            boot_cpu_pkg::ID:     state_next = boot_cpu_pkg::ID_EX;
            boot_cpu_pkg::ID_EX:  state_next = boot_cpu_pkg::EX_MEM;
            boot_cpu_pkg::EX_MEM: state_next = boot_cpu_pkg::MEM;
            boot_cpu_pkg::MEM: begin
                if (!stall) begin // wait for the last stdout byte.
                    state_next = boot_cpu_pkg::MEM_WB;
                end
            end
            boot_cpu_pkg::MEM_WB: state_next = boot_cpu_pkg::WB;
            boot_cpu_pkg::WB:     state_next = boot_cpu_pkg::WB_IF;
            boot_cpu_pkg::WB_IF:  state_next = boot_cpu_pkg::IF;
            default:              state_next = boot_cpu_pkg::INIT;
        endcase
    end

    ////////////////////
    // output decode
    ////////////////////

    always_comb begin
        boot_ctrl = '0;
        enables   = '0;
        boot_ctrl.run = state inside {[boot_cpu_pkg::IF:boot_cpu_pkg::WB_IF]};
        enables.pipeline_reset_n = boot_ctrl.run; // pipeline held clear while booting.
        case (state)
            boot_cpu_pkg::TRANSMIT_SYNC:   boot_ctrl.transmit_sync = 1'b1;
            boot_cpu_pkg::RECEIVE_SIZE:    boot_ctrl.receive_size = 1'b1;
            boot_cpu_pkg::RECEIVE_PROGRAM: boot_ctrl.receive_program = 1'b1;
            boot_cpu_pkg::TRANSMIT_DONE:   boot_ctrl.transmit_done = 1'b1;
            boot_cpu_pkg::IF_ID:           enables.if_id = 1'b1;
            boot_cpu_pkg::ID_EX:           enables.id_ex = 1'b1;
            boot_cpu_pkg::EX_MEM:          enables.ex_mem = 1'b1;
            boot_cpu_pkg::MEM: begin
                // only on the leaving cycle.
                enables.stdout_write = !stall;
                enables.ram_write    = !stall;
            end
            boot_cpu_pkg::MEM_WB:          enables.mem_wb = 1'b1;
            boot_cpu_pkg::WB:              enables.reg_write = 1'b1;
            boot_cpu_pkg::WB_IF:           enables.wb_if = 1'b1;
            default: begin
            end
        endcase
    end

endmodule

// File: design/host_link.sv
`timescale 1ns/1ps
`include "boot_cpu_macros.svh"

module host_link (
    input  logic                     clk,
    input  logic                     reset_n,
    input  boot_cpu_pkg::boot_ctrl_t boot_ctrl,
    input  logic                     stdout_write,
    input  logic [7:0]               stdout_byte,
    input  logic                     rx_valid,
    input  logic [7:0]               rx_data,
    input  logic                     tx_ready,
    output logic                     tx_valid,
    output logic [7:0]               tx_data,
    output logic [7:0]               stdin_byte,
    output logic                     sync_sent,
    output logic                     done_sent,
    output logic                     stall
);

    logic       pending;
    logic [7:0] stdout_reg;
    logic       taken;

    assign tx_valid = boot_ctrl.transmit_sync || boot_ctrl.transmit_done
                      || (boot_ctrl.run && pending);
    assign tx_data  = boot_ctrl.transmit_sync ? `BOOT_SYNC_BYTE :
                      boot_ctrl.transmit_done ? `BOOT_DONE_BYTE : stdout_reg;

    assign taken     = tx_valid && tx_ready;
    assign sync_sent = taken && boot_ctrl.transmit_sync;
    assign done_sent = taken && boot_ctrl.transmit_done;
    assign stall     = pending;

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            stdin_byte <= '0;
            pending    <= 1'b0;
        end else begin
            if (boot_ctrl.run && rx_valid) begin
                stdin_byte <= rx_data; // newest byte wins.
            end
            if (stdout_write) begin
                pending <= 1'b1;
            end else if (boot_ctrl.run && taken) begin
                pending <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (stdout_write) begin
            stdout_reg <= stdout_byte;
        end
    end

endmodule

// File: design/program_loader.sv
`timescale 1ns/1ps
`include "boot_cpu_macros.svh"

module program_loader (
    input  logic                     clk,
    input  logic                     reset_n,
    input  boot_cpu_pkg::boot_ctrl_t boot_ctrl,
    input  logic                     rx_valid,
    input  logic [7:0]               rx_data,
    output boot_cpu_pkg::ram_write_t ram_write,
    output logic                     size_received,
    output logic                     program_received
);

    logic                        size_half;
    logic [7:0]                  size_low;
    logic [15:0]                 size_word;
    logic [`BOOT_ADDR_WIDTH-1:0] last_addr;
    logic [`BOOT_ADDR_WIDTH-1:0] last_addr_next;
    logic                        word_half;
    logic [7:0]                  high_byte;
    logic [`BOOT_ADDR_WIDTH-1:0] write_addr;
    logic                        word_done;

    // size arrives low byte first; clamp to 1..256 words.
    assign size_word      = {rx_data, size_low};
    assign last_addr_next = (size_word > 16'd256) ? '1 :
                            (size_word == 16'd0)  ? '0 :
                            `BOOT_ADDR_WIDTH'(size_word - 16'd1);

    assign size_received    = boot_ctrl.receive_size && rx_valid && size_half;
    assign word_done        = boot_ctrl.receive_program && rx_valid && word_half;
    assign program_received = word_done && (write_addr == last_addr);

    always_comb begin
        ram_write = '0;
        if (word_done) begin
            ram_write.en   = 1'b1;
            ram_write.addr = write_addr;
            ram_write.data = {high_byte, rx_data}; // high byte came first.
        end
    end

    always_ff @(posedge clk) begin
        if (!reset_n) begin
            size_half  <= 1'b0;
            last_addr  <= '0;
            word_half  <= 1'b0;
            write_addr <= '0;
        end else begin
            if (boot_ctrl.receive_size && rx_valid) begin
                size_half <= !size_half;
                if (size_half) begin
                    last_addr <= last_addr_next;
                end
            end
            if (boot_ctrl.receive_program && rx_valid) begin
                word_half <= !word_half;
                if (word_half) begin
                    write_addr <= write_addr + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (boot_ctrl.receive_size && rx_valid && !size_half) begin
            size_low <= rx_data;
        end
        if (boot_ctrl.receive_program && rx_valid && !word_half) begin
            high_byte <= rx_data;
        end
    end

endmodule

// File: design/program_ram.sv
`timescale 1ns/1ps
`include "boot_cpu_macros.svh"

module program_ram (
    input  logic                        clk,
    input  boot_cpu_pkg::ram_write_t    ram_write,
    input  logic [`BOOT_ADDR_WIDTH-1:0] fetch_addr,
    input  logic [`BOOT_ADDR_WIDTH-1:0] data_addr,
    output logic [`BOOT_WORD_WIDTH-1:0] fetch_word,
    output logic [`BOOT_WORD_WIDTH-1:0] data_word
);

    logic [`BOOT_WORD_WIDTH-1:0] mem [0:(1 << `BOOT_ADDR_WIDTH)-1];

    always_ff @(posedge clk) begin
        if (ram_write.en) begin
            mem[ram_write.addr] <= ram_write.data;
        end
    end

    // both read ports are asynchronous.
    assign fetch_word = mem[fetch_addr];
    assign data_word  = mem[data_addr];

endmodule

// File: design/accumulator_core.sv
`timescale 1ns/1ps
`include "boot_cpu_macros.svh"

module accumulator_core (
    input  logic                         clk,
    input  logic                         reset_n,
    input  boot_cpu_pkg::stage_enables_t enables,
    input  logic [7:0]                   stdin_byte,
    output logic [`BOOT_ADDR_WIDTH-1:0]  fetch_addr,
    input  logic [`BOOT_WORD_WIDTH-1:0]  fetch_word,
    output logic [`BOOT_ADDR_WIDTH-1:0]  data_addr,
    input  logic [`BOOT_WORD_WIDTH-1:0]  data_word,
    output boot_cpu_pkg::ram_write_t     ram_write,
    output logic                         stdout_write,
    output logic [7:0]                   stdout_byte
);

    typedef struct packed {
        boot_cpu_pkg::opcode_e       op;
        logic [7:0]                  value;
        logic [`BOOT_ADDR_WIDTH-1:0] addr;  // store address or branch target.
        logic                        taken;
    } stage_t;

    logic                        clear;
    logic [`BOOT_ADDR_WIDTH-1:0] pc;
    logic [7:0]                  acc;
    boot_cpu_pkg::instr_t        if_id;
    boot_cpu_pkg::instr_t        id_ex;
    stage_t                      ex_result;
    stage_t                      ex_mem;
    stage_t                      mem_wb;
    logic                        writes_acc;

    assign clear      = !reset_n || !enables.pipeline_reset_n;
    assign fetch_addr = pc;
    assign data_addr  = id_ex.operand; // LD reads during EX.

    ////////////////////
    // EX
    ////////////////////

    always_comb begin
        ex_result.op    = id_ex.op;
        ex_result.value = acc;
        ex_result.addr  = id_ex.operand;
        ex_result.taken = 1'b0;
        case (id_ex.op)
            boot_cpu_pkg::LDI:  ex_result.value = id_ex.operand;
            boot_cpu_pkg::ADDI: ex_result.value = acc + id_ex.operand;
            boot_cpu_pkg::SUBI: ex_result.value = acc - id_ex.operand;
            boot_cpu_pkg::LD:   ex_result.value = data_word[7:0];
            boot_cpu_pkg::IN:   ex_result.value = stdin_byte;
            boot_cpu_pkg::JMP:  ex_result.taken = 1'b1;
            boot_cpu_pkg::JZ:   ex_result.taken = (acc == 8'd0);
            default: begin
            end
        endcase
    end

    ////////////////////
    // MEM and WB
    ////////////////////

    always_comb begin
        ram_write = '0;
        if (enables.ram_write && ex_mem.op == boot_cpu_pkg::ST) begin
            ram_write.en   = 1'b1;
            ram_write.addr = ex_mem.addr;
            ram_write.data = `BOOT_WORD_WIDTH'(ex_mem.value);
        end
    end

    assign stdout_write = enables.stdout_write && (ex_mem.op == boot_cpu_pkg::OUT);
    assign stdout_byte  = ex_mem.value;

    assign writes_acc = mem_wb.op inside {boot_cpu_pkg::LDI, boot_cpu_pkg::ADDI,
                                          boot_cpu_pkg::SUBI, boot_cpu_pkg::LD,
                                          boot_cpu_pkg::IN};

    always_ff @(posedge clk) begin
        if (clear) begin
            pc     <= '0;
            acc    <= '0;
            if_id  <= '0;
            id_ex  <= '0;
            ex_mem <= '0;
            mem_wb <= '0;
        end else begin
            if (enables.if_id) begin
                if_id <= boot_cpu_pkg::instr_t'(fetch_word);
            end
            if (enables.id_ex) begin
                id_ex <= if_id;
            end
            if (enables.ex_mem) begin
                ex_mem <= ex_result;
            end
            if (enables.mem_wb) begin
                mem_wb <= ex_mem;
            end
            if (enables.reg_write && writes_acc) begin
                acc <= mem_wb.value;
            end
            if (enables.wb_if) begin
                pc <= mem_wb.taken ? mem_wb.addr : pc + 1'b1; // redirect or step.
            end
        end
    end

endmodule

// File: design/boot_cpu_top.sv
`timescale 1ns/1ps
`include "boot_cpu_macros.svh"

module boot_cpu_top (
    input  logic       clk,
    input  logic       reset_n,
    input  logic       rx_valid,
    input  logic [7:0] rx_data,
    input  logic       tx_ready,
    output logic       tx_valid,
    output logic [7:0] tx_data
);

    boot_cpu_pkg::boot_ctrl_t     boot_ctrl;
    boot_cpu_pkg::boot_status_t   status;
    boot_cpu_pkg::stage_enables_t enables;
    boot_cpu_pkg::ram_write_t     loader_write;
    boot_cpu_pkg::ram_write_t     core_write;
    boot_cpu_pkg::ram_write_t     ram_write;
    logic                         stall;
    logic                         stdout_write;
    logic [7:0]                   stdout_byte;
    logic [7:0]                   stdin_byte;
    logic [`BOOT_ADDR_WIDTH-1:0]  fetch_addr;
    logic [`BOOT_ADDR_WIDTH-1:0]  data_addr;
    logic [`BOOT_WORD_WIDTH-1:0]  fetch_word;
    logic [`BOOT_WORD_WIDTH-1:0]  data_word;

    // loader and core never write in the same phase.
    assign ram_write = boot_cpu_pkg::ram_write_t'(loader_write | core_write);

    state_controller state_controller_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .stall     (stall),
        .status    (status),
        .boot_ctrl (boot_ctrl),
        .enables   (enables)
    );

    host_link host_link_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .boot_ctrl    (boot_ctrl),
        .stdout_write (stdout_write),
        .stdout_byte  (stdout_byte),
        .rx_valid     (rx_valid),
        .rx_data      (rx_data),
        .tx_ready     (tx_ready),
        .tx_valid     (tx_valid),
        .tx_data      (tx_data),
        .stdin_byte   (stdin_byte),
        .sync_sent    (status.sync_sent),
        .done_sent    (status.done_sent),
        .stall        (stall)
    );

    program_loader program_loader_inst (
        .clk              (clk),
        .reset_n          (reset_n),
        .boot_ctrl        (boot_ctrl),
        .rx_valid         (rx_valid),
        .rx_data          (rx_data),
        .ram_write        (loader_write),
        .size_received    (status.size_received),
        .program_received (status.program_received)
    );

    program_ram program_ram_inst (
        .clk        (clk),
        .ram_write  (ram_write),
        .fetch_addr (fetch_addr),
        .data_addr  (data_addr),
        .fetch_word (fetch_word),
        .data_word  (data_word)
    );

    accumulator_core accumulator_core_inst (
        .clk          (clk),
        .reset_n      (reset_n),
        .enables      (enables),
        .stdin_byte   (stdin_byte),
        .fetch_addr   (fetch_addr),
        .fetch_word   (fetch_word),
        .data_addr    (data_addr),
        .data_word    (data_word),
        .ram_write    (core_write),
        .stdout_write (stdout_write),
        .stdout_byte  (stdout_byte)
    );

endmodule

// File: verification/boot_cpu_tb.sv
`timescale 1ns/1ps
`include "boot_cpu_macros.svh"

module boot_cpu_tb;

    localparam int RESET_CYCLES = 4;
    localparam int MAX_WORDS    = 16;
    localparam int BOOT_CYCLES  = 8 + 2 * MAX_WORDS;
    localparam int MAX_INSTRS   = 50;
    localparam int MAX_GAP      = 20; // tx_ready gating per instruction.
    localparam int QUIET_CYCLES = 40;
    localparam int TEST_COUNT   = 6;
    localparam int TEST_BUDGET  = RESET_CYCLES + BOOT_CYCLES
                                  + MAX_INSTRS * (9 + MAX_GAP) + QUIET_CYCLES;
    localparam int CYCLE_LIMIT  = TEST_COUNT * TEST_BUDGET + 1000;
    localparam int WAIT_LIMIT   = 400;

    logic       clk;
    logic       reset_n;
    logic       rx_valid;
    logic [7:0] rx_data;
    logic       tx_ready;
    logic       tx_valid;
    logic [7:0] tx_data;

    int          error_count;
    int          check_count;
    int          cycle_count;
    logic [15:0] program_words [$];

    boot_cpu_top boot_cpu_top_inst (
        .clk      (clk),
        .reset_n  (reset_n),
        .rx_valid (rx_valid),
        .rx_data  (rx_data),
        .tx_ready (tx_ready),
        .tx_valid (tx_valid),
        .tx_data  (tx_data)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    ////////////////////
    // compare tasks
    ////////////////////

    task automatic check_byte(input string test, input logic [7:0] expected,
                              input logic [7:0] actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected 8'h%02h, actual 8'h%02h", test, expected, actual);
        end
    endtask

    task automatic check_state(input string test, input boot_cpu_pkg::ctrl_state_e expected,
                               input boot_cpu_pkg::ctrl_state_e actual);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("CHECK FAILED %s: expected %s, actual %s", test, expected.name(),
                     actual.name());
        end
    endtask

    ////////////////////
    // host side
    ////////////////////

    // three reset edges; leaves us 1 ns after the first non-reset edge.
    task automatic apply_reset(input string test, output boot_cpu_pkg::ctrl_state_e seen);
        reset_n  = 1'b0;
        rx_valid = 1'b0;
        rx_data  = 8'h00;
        tx_ready = 1'b0;
        for (int i = 0; i < 3; i++) begin
            @(posedge clk);
            #1;
            if (i == 2) begin
                reset_n = 1'b1;
            end
            @(negedge clk);
            if (tx_valid !== 1'b0) begin
                error_count++;
                $display("%s: tx_valid was not low during reset", test);
            end
        end
        seen = boot_cpu_top_inst.state_controller_inst.state;
        @(posedge clk);
        #1;
    endtask

    task automatic send_byte(input logic [7:0] data);
        rx_valid = 1'b1;
        rx_data  = data;
        @(posedge clk);
        #1;
        rx_valid = 1'b0;
    endtask

    task automatic receive_byte(input string test, input bit gated, output logic [7:0] data);
        int gap;
        int waited;
        bit got;
        gap    = gated ? int'($urandom % 4) : 0;
        waited = 0;
        got    = 1'b0;
        data   = 'x;
        while (!got && waited < WAIT_LIMIT) begin
            tx_ready = (waited >= gap);
            @(negedge clk);
            if (tx_valid && tx_ready) begin
                data = tx_data; // taken on the coming edge.
                got  = 1'b1;
            end
            @(posedge clk);
            #1;
            waited++;
        end
        tx_ready = 1'b0;
        if (!got) begin
            error_count++;
            $display("%s: no byte was offered on tx within %0d cycles", test, WAIT_LIMIT);
        end
    endtask

    task automatic expect_quiet(input string test, input int cycles);
        tx_ready = 1'b0;
        repeat (cycles) begin
            @(negedge clk);
            if (tx_valid !== 1'b0) begin
                error_count++;
                $display("%s: unexpected byte 8'h%02h offered on tx", test, tx_data);
            end
            @(posedge clk);
            #1;
        end
    endtask

    task automatic emit(input boot_cpu_pkg::opcode_e op, input logic [7:0] operand);
        boot_cpu_pkg::instr_t word;
        word.op      = op;
        word.unused  = 4'h0;
        word.operand = operand;
        program_words.push_back(word);
    endtask

    // sync, size low byte first, words high byte first, then done.
    task automatic boot_program(input string test);
        logic [7:0]  data;
        logic [15:0] size;
        receive_byte(test, 1'b0, data);
        check_byte({test, " sync"}, `BOOT_SYNC_BYTE, data);
        size = 16'(program_words.size());
        send_byte(size[7:0]);
        send_byte(size[15:8]);
        foreach (program_words[i]) begin
            send_byte(program_words[i][15:8]);
            send_byte(program_words[i][7:0]);
        end
        receive_byte(test, 1'b0, data);
        check_byte({test, " done"}, `BOOT_DONE_BYTE, data);
    endtask

    ////////////////////
    // directed tests
    ////////////////////

    task automatic reset_outputs();
        boot_cpu_pkg::ctrl_state_e seen;
        apply_reset("reset_outputs", seen);
        check_state("reset_outputs", boot_cpu_pkg::INIT, seen);
        check_state("reset_outputs", boot_cpu_pkg::TRANSMIT_SYNC,
                    boot_cpu_top_inst.state_controller_inst.state);
        repeat (6) begin
            @(negedge clk);
            if (tx_valid !== 1'b1) begin
                error_count++;
                $display("reset_outputs: sync byte was not held on tx");
            end
            check_byte("reset_outputs", `BOOT_SYNC_BYTE, tx_data);
            @(posedge clk);
            #1;
        end
    endtask

    task automatic boot_handshake();
        boot_cpu_pkg::ctrl_state_e seen;
        logic [7:0] value;
        logic [7:0] data;
        int count;
        apply_reset("boot_handshake", seen);
        value = 8'($urandom);
        program_words.delete();
        count = 3 + int'($urandom % 8);
        repeat (count) emit(boot_cpu_pkg::NOP, 8'h00);
        emit(boot_cpu_pkg::LDI, value);
        emit(boot_cpu_pkg::OUT, 8'h00); // must not beat the done byte.
        emit(boot_cpu_pkg::JMP, 8'(program_words.size())); // spin here.
        boot_program("boot_handshake");
        receive_byte("boot_handshake", 1'b0, data);
        check_byte("boot_handshake", value, data);
        expect_quiet("boot_handshake", QUIET_CYCLES);
    endtask

    task automatic arithmetic_out();
        boot_cpu_pkg::ctrl_state_e seen;
        logic [7:0] a;
        logic [7:0] b;
        logic [7:0] c;
        logic [7:0] data;
        apply_reset("arithmetic_out", seen);
        a = 8'($urandom);
        b = 8'($urandom);
        c = 8'($urandom);
        program_words.delete();
        emit(boot_cpu_pkg::LDI, a);
        emit(boot_cpu_pkg::OUT, 8'h00);
        emit(boot_cpu_pkg::ADDI, b);
        emit(boot_cpu_pkg::SUBI, c);
        emit(boot_cpu_pkg::OUT, 8'h00);
        emit(boot_cpu_pkg::JMP, 8'(program_words.size()));
        boot_program("arithmetic_out");
        receive_byte("arithmetic_out", 1'b0, data);
        check_byte("arithmetic_out", a, data);
        receive_byte("arithmetic_out", 1'b0, data);
        check_byte("arithmetic_out", 8'(a + b - c), data); // wraps at 256.
    endtask

    task automatic memory_and_branch();
        boot_cpu_pkg::ctrl_state_e seen;
        logic [7:0] n;
        logic [7:0] data;
        apply_reset("memory_and_branch", seen);
        n = 8'(3 + $urandom % 4);
        program_words.delete();
        emit(boot_cpu_pkg::LDI, n);
        emit(boot_cpu_pkg::ST, 8'h80);
        emit(boot_cpu_pkg::LD, 8'h80);   // loop head at 2.
        emit(boot_cpu_pkg::JZ, 8'd8);
        emit(boot_cpu_pkg::OUT, 8'h00);
        emit(boot_cpu_pkg::SUBI, 8'd1);
        emit(boot_cpu_pkg::ST, 8'h80);
        emit(boot_cpu_pkg::JMP, 8'd2);
        emit(boot_cpu_pkg::JMP, 8'd8);
        boot_program("memory_and_branch");
        for (int i = int'(n); i >= 1; i--) begin
            receive_byte("memory_and_branch", 1'b0, data);
            check_byte("memory_and_branch", 8'(i), data);
        end
        expect_quiet("memory_and_branch", QUIET_CYCLES);
    endtask

    task automatic stdin_echo();
        boot_cpu_pkg::ctrl_state_e seen;
        logic [7:0] value;
        logic [7:0] data;
        apply_reset("stdin_echo", seen);
        value = 8'(1 + $urandom % 255); // nonzero, unlike the reset value.
        program_words.delete();
        emit(boot_cpu_pkg::NOP, 8'h00);
        emit(boot_cpu_pkg::NOP, 8'h00);
        emit(boot_cpu_pkg::IN, 8'h00);
        emit(boot_cpu_pkg::ADDI, 8'd1);
        emit(boot_cpu_pkg::OUT, 8'h00);
        emit(boot_cpu_pkg::JMP, 8'(program_words.size()));
        boot_program("stdin_echo");
        send_byte(value); // arrives well before IN reaches EX.
        receive_byte("stdin_echo", 1'b0, data);
        check_byte("stdin_echo", 8'(value + 8'd1), data);
    endtask

    task automatic tx_backpressure();
        boot_cpu_pkg::ctrl_state_e seen;
        logic [7:0] sent [$];
        logic [7:0] data;
        int count;
        int hold;
        apply_reset("tx_backpressure", seen);
        count = 4 + int'($urandom % 3);
        program_words.delete();
        repeat (count) begin
            sent.push_back(8'($urandom));
            emit(boot_cpu_pkg::LDI, sent[$]);
            emit(boot_cpu_pkg::OUT, 8'h00);
        end
        emit(boot_cpu_pkg::JMP, 8'(program_words.size()));
        boot_program("tx_backpressure");
        // second OUT sits in MEM while the first byte waits.
        hold = 4 * 9 + int'($urandom % MAX_GAP);
        repeat (hold) begin
            @(posedge clk);
            #1;
        end
        foreach (sent[i]) begin
            receive_byte("tx_backpressure", 1'b1, data);
            check_byte("tx_backpressure", sent[i], data);
        end
        expect_quiet("tx_backpressure", QUIET_CYCLES);
    endtask

    ////////////////////
    // run control
    ////////////////////

    initial begin
        cycle_count = 0;
        while (cycle_count < CYCLE_LIMIT) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped after %0d cycles without finishing the tests", cycle_count);
        $display("Test failures found");
        $finish;
    end

    initial begin
        void'($urandom(96));
        reset_n     = 1'b0;
        rx_valid    = 1'b0;
        rx_data     = 8'h00;
        tx_ready    = 1'b0;
        error_count = 0;
        check_count = 0;
        @(posedge clk);
        #1;
        reset_outputs();
        boot_handshake();
        arithmetic_out();
        memory_and_branch();
        stdin_echo();
        tx_backpressure();
        $display("%0d checks, %0d errors", check_count, error_count);
        if (error_count == 0) begin
            $display("All tests passed!");
        end else begin
            $display("Test failures found");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+include
design/boot_cpu_pkg.sv
design/state_controller.sv
design/host_link.sv
design/program_loader.sv
design/program_ram.sv
design/accumulator_core.sv
design/boot_cpu_top.sv
verification/boot_cpu_tb.sv

// File: Bender.yml
package:
  name: boot_cpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - design/boot_cpu_pkg.sv
      - design/state_controller.sv
      - design/host_link.sv
      - design/program_loader.sv
      - design/program_ram.sv
      - design/accumulator_core.sv
      - design/boot_cpu_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/boot_cpu_tb.sv
